//--- Makefile
TOP = debug_unit_tb

all: run

build:
	verilator --binary --timing -Wno-fatal -f debug_unit.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Finished with errors" sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --timing -f debug_unit.f --top-module debug_unit

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- debug_unit.f
hdl/debug_geom_pkg.sv
hdl/debug_cmd_pkg.sv
hdl/rx_byte_decoder.sv
hdl/program_loader.sv
hdl/debug_control.sv
hdl/readout_sender.sv
hdl/debug_unit.sv
verif/debug_unit_tb.sv

//--- hdl/debug_cmd_pkg.sv
package debug_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Host command codes
  ////////////////////////////////////////////////////////////////////////////

  localparam debug_geom_pkg::byte_t CMD_SOFT_RESET = 8'h00;   // Reset the processor.
  localparam debug_geom_pkg::byte_t CMD_LOAD       = 8'h01;   // Also the load-ready ack.
  localparam debug_geom_pkg::byte_t CMD_RUN_CONT   = 8'h03;   // Run until halt.
  localparam debug_geom_pkg::byte_t CMD_RUN_STEP   = 8'h07;   // Bit 2 set means step.

  ////////////////////////////////////////////////////////////////////////////
  // Host acknowledge codes, most significant byte first
  ////////////////////////////////////////////////////////////////////////////

  localparam debug_geom_pkg::byte_t ACK_BYTE3 = 8'h08;
  localparam debug_geom_pkg::byte_t ACK_BYTE2 = 8'h10;
  localparam debug_geom_pkg::byte_t ACK_BYTE1 = 8'h18;
  localparam debug_geom_pkg::byte_t ACK_BYTE0 = 8'h20;

  // Debug control FSM states.
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SOFT_RESET,
    ST_WAIT_LOAD,
    ST_LOAD,
    ST_WAIT_START,
    ST_EXEC,
    ST_READOUT
  } ctrl_state_t;

endpackage

//--- hdl/debug_control.sv
`timescale 1ns/1ps

module debug_control (
  input  logic i_clock,
  input  logic i_reset,
  input  logic i_cmd_soft_reset,
  input  logic i_cmd_load,
  input  logic i_cmd_run,
  input  logic i_run_step,
  input  logic i_soft_reset_ack,
  input  logic i_halt,
  input  logic i_load_done,
  input  logic i_readout_done,
  output logic o_soft_reset,
  output logic o_load_enable,
  output logic o_load_ack,
  output logic o_enable_pc,
  output logic o_enable_pipeline,
  output logic o_mem_select_loader,
  output logic o_readout_start
);

  import debug_cmd_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        step_q;
  logic        exec_active;
  logic        exec_last;

  ////////////////////////////////////////////////////////////////////////////
  // State register and run mode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state_q <= ST_IDLE;
      step_q  <= 1'b0;                                        // Continuous.
    end else begin
      state_q <= state_d;
      if (state_q == ST_WAIT_START && i_cmd_run) begin
        step_q <= i_run_step;                                // Latch mode per run.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (i_cmd_soft_reset) begin
          state_d = ST_SOFT_RESET;
        end
      end
      ST_SOFT_RESET: begin
        if (!i_soft_reset_ack) begin
          state_d = ST_WAIT_LOAD;                            // Processor is reset.
        end
      end
      ST_WAIT_LOAD: begin
        if (i_cmd_load) begin
          state_d = ST_LOAD;
        end
      end
      ST_LOAD: begin
        if (i_load_done) begin
          state_d = ST_WAIT_START;
        end
      end
      ST_WAIT_START: begin
        if (i_cmd_run) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (exec_last) begin
          state_d = ST_READOUT;
        end
      end
      ST_READOUT: begin
        if (i_readout_done) begin
          if (!step_q || i_halt) begin
            state_d = ST_IDLE;
          end else begin
            state_d = ST_WAIT_START;                         // Ready for next step.
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control outputs
  ////////////////////////////////////////////////////////////////////////////

  // A step lasts one cycle; continuous mode stops on halt.
  assign exec_last   = (state_q == ST_EXEC) && (step_q || i_halt);
  assign exec_active = (state_q == ST_EXEC) && (step_q || !i_halt);

  assign o_soft_reset      = (state_q != ST_SOFT_RESET);      // Active low.
  assign o_load_ack        = (state_q == ST_WAIT_LOAD);
  assign o_load_enable     = (state_q == ST_LOAD);
  assign o_enable_pc       = exec_active;
  assign o_enable_pipeline = exec_active;                     // Same edge as the PC.
  assign o_readout_start   = exec_last;

  assign o_mem_select_loader = (state_q == ST_IDLE) || (state_q == ST_SOFT_RESET) ||
                               (state_q == ST_WAIT_LOAD) || (state_q == ST_LOAD);

endmodule

//--- hdl/debug_geom_pkg.sv
package debug_geom_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths of the UART byte and of the processor word
  ////////////////////////////////////////////////////////////////////////////

  localparam int BYTE_WIDTH     = 8;                           // UART byte.
  localparam int WORD_WIDTH     = 32;                          // Instruction or readout word.
  localparam int BYTES_PER_WORD = WORD_WIDTH / BYTE_WIDTH;     // Four bytes per word.

  typedef logic [BYTE_WIDTH-1:0] byte_t;
  typedef logic [WORD_WIDTH-1:0] word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Program encoding
  ////////////////////////////////////////////////////////////////////////////

  // All-ones word ends a program download.
  localparam word_t DEFAULT_HALT_WORD = 32'hFFFF_FFFF;

endpackage

//--- hdl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit #(
  parameter int                    ADDR_WIDTH    = 11,
  parameter int                    READOUT_WORDS = 10,
  parameter debug_geom_pkg::word_t HALT_WORD     = debug_geom_pkg::DEFAULT_HALT_WORD
) (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_rx_done,
  input  debug_geom_pkg::byte_t            i_data_rx,
  output logic                             o_tx_start,
  output debug_geom_pkg::byte_t            o_data_tx,
  output logic                             o_soft_reset,
  output logic                             o_enable_pc,
  output logic                             o_enable_pipeline,
  output logic                             o_mem_select_loader,
  input  logic                             i_soft_reset_ack,
  input  logic                             i_halt,
  output logic                             o_write_mem,
  output logic [ADDR_WIDTH-1:0]            o_addr_mem,
  output debug_geom_pkg::word_t            o_data_mem,
  output logic [$clog2(READOUT_WORDS)-1:0] o_readout_select,
  input  debug_geom_pkg::word_t            i_readout_word
);

  import debug_geom_pkg::*;

  logic  byte_valid;
  byte_t rx_byte;
  logic  cmd_soft_reset;
  logic  cmd_load;
  logic  cmd_run;
  logic  run_step;
  logic  load_enable;
  logic  load_done;
  logic  load_ack;
  logic  readout_start;
  logic  readout_done;

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  rx_byte_decoder rx_byte_decoder_i (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_done        (i_rx_done),
    .i_data_rx        (i_data_rx),
    .o_byte_valid     (byte_valid),
    .o_byte           (rx_byte),
    .o_cmd_soft_reset (cmd_soft_reset),
    .o_cmd_load       (cmd_load),
    .o_cmd_run        (cmd_run),
    .o_run_step       (run_step)
  );

  program_loader #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .HALT_WORD  (HALT_WORD)
  ) program_loader_i (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_load_enable (load_enable),
    .i_byte_valid  (byte_valid),
    .i_byte        (rx_byte),
    .o_write_mem   (o_write_mem),
    .o_addr_mem    (o_addr_mem),
    .o_data_mem    (o_data_mem),
    .o_load_done   (load_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Control and output side
  ////////////////////////////////////////////////////////////////////////////

  debug_control debug_control_i (
    .i_clock             (i_clock),
    .i_reset             (i_reset),
    .i_cmd_soft_reset    (cmd_soft_reset),
    .i_cmd_load          (cmd_load),
    .i_cmd_run           (cmd_run),
    .i_run_step          (run_step),
    .i_soft_reset_ack    (i_soft_reset_ack),
    .i_halt              (i_halt),
    .i_load_done         (load_done),
    .i_readout_done      (readout_done),
    .o_soft_reset        (o_soft_reset),
    .o_load_enable       (load_enable),
    .o_load_ack          (load_ack),
    .o_enable_pc         (o_enable_pc),
    .o_enable_pipeline   (o_enable_pipeline),
    .o_mem_select_loader (o_mem_select_loader),
    .o_readout_start     (readout_start)
  );

  readout_sender #(
    .READOUT_WORDS (READOUT_WORDS)
  ) readout_sender_i (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_readout_start  (readout_start),
    .i_byte_valid     (byte_valid),
    .i_byte           (rx_byte),
    .i_readout_word   (i_readout_word),
    .i_load_ack       (load_ack),
    .o_tx_start       (o_tx_start),
    .o_data_tx        (o_data_tx),
    .o_readout_select (o_readout_select),
    .o_readout_done   (readout_done)
  );

endmodule

//--- hdl/program_loader.sv
`timescale 1ns/1ps

module program_loader #(
  parameter int                    ADDR_WIDTH = 11,
  parameter debug_geom_pkg::word_t HALT_WORD  = debug_geom_pkg::DEFAULT_HALT_WORD
) (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_load_enable,
  input  logic                  i_byte_valid,
  input  debug_geom_pkg::byte_t i_byte,
  output logic                  o_write_mem,
  output logic [ADDR_WIDTH-1:0] o_addr_mem,
  output debug_geom_pkg::word_t o_data_mem,
  output logic                  o_load_done
);

  import debug_geom_pkg::*;

  localparam int CNT_WIDTH = $clog2(BYTES_PER_WORD);
  localparam logic [CNT_WIDTH-1:0] LAST_BYTE = CNT_WIDTH'(BYTES_PER_WORD - 1);

  word_t                 word_q;
  logic [CNT_WIDTH-1:0]  count_q;
  logic                  full_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  is_halt;
  logic                  write_word;

  ////////////////////////////////////////////////////////////////////////////
  // Word assembly
  ////////////////////////////////////////////////////////////////////////////

  // Big-endian, so each new byte enters at the bottom.
  always_ff @(posedge i_clock) begin
    if (i_load_enable && i_byte_valid) begin
      word_q <= {word_q[WORD_WIDTH-BYTE_WIDTH-1:0], i_byte};
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      count_q <= '0;
      full_q  <= 1'b0;
      addr_q  <= '0;
    end else if (!i_load_enable) begin
      count_q <= '0;                                          // Restart on next load.
      full_q  <= 1'b0;
      addr_q  <= '0;
    end else begin
      full_q <= i_byte_valid && (count_q == LAST_BYTE);        // Fourth byte seen.
      if (i_byte_valid) begin
        count_q <= count_q + 1'b1;                           // Wraps after a word.
      end
      if (write_word) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write or finish
  ////////////////////////////////////////////////////////////////////////////

  assign is_halt    = (word_q == HALT_WORD);
  assign write_word = full_q && !is_halt;

  assign o_write_mem = write_word;
  assign o_load_done = full_q && is_halt;                    // HALT is never written.
  assign o_addr_mem  = addr_q;
  assign o_data_mem  = word_q;

endmodule

//--- hdl/readout_sender.sv
`timescale 1ns/1ps

module readout_sender #(
  parameter int READOUT_WORDS = 10
) (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_readout_start,
  input  logic                             i_byte_valid,
  input  debug_geom_pkg::byte_t            i_byte,
  input  debug_geom_pkg::word_t            i_readout_word,
  input  logic                             i_load_ack,
  output logic                             o_tx_start,
  output debug_geom_pkg::byte_t            o_data_tx,
  output logic [$clog2(READOUT_WORDS)-1:0] o_readout_select,
  output logic                             o_readout_done
);

  import debug_geom_pkg::*;
  import debug_cmd_pkg::*;

  localparam int SEL_WIDTH = $clog2(READOUT_WORDS);
  localparam int CNT_WIDTH = $clog2(BYTES_PER_WORD);
  localparam logic [SEL_WIDTH-1:0] LAST_WORD  = SEL_WIDTH'(READOUT_WORDS - 1);
  localparam logic [CNT_WIDTH-1:0] FIRST_BYTE = CNT_WIDTH'(BYTES_PER_WORD - 1);

  logic                 active_q;
  logic                 gap_q;
  logic [SEL_WIDTH-1:0] word_idx_q;
  logic [CNT_WIDTH-1:0] byte_idx_q;
  logic                 sending;
  logic                 ack_ok;
  byte_t                ack_code;
  byte_t                tx_byte;

  assign sending = active_q && !gap_q;
  assign tx_byte = i_readout_word[byte_idx_q*BYTE_WIDTH +: BYTE_WIDTH];

  // Ack expected for the byte on the line.
  always_comb begin
    case (byte_idx_q)
      2'd3:    ack_code = ACK_BYTE3;
      2'd2:    ack_code = ACK_BYTE2;
      2'd1:    ack_code = ACK_BYTE1;
      default: ack_code = ACK_BYTE0;
    endcase
  end

  assign ack_ok = sending && i_byte_valid && (i_byte == ack_code);  // Others ignored.

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      active_q       <= 1'b0;
      gap_q          <= 1'b0;
      word_idx_q     <= '0;
      byte_idx_q     <= FIRST_BYTE;
      o_readout_done <= 1'b0;
    end else begin
      o_readout_done <= 1'b0;
      gap_q          <= 1'b0;                                 // Gap lasts one cycle.
      if (i_readout_start) begin
        active_q   <= 1'b1;
        word_idx_q <= '0;
        byte_idx_q <= FIRST_BYTE;
      end else if (ack_ok) begin
        if (byte_idx_q != '0) begin
          byte_idx_q <= byte_idx_q - 1'b1;
        end else if (word_idx_q == LAST_WORD) begin
          active_q       <= 1'b0;
          o_readout_done <= 1'b1;                            // Last ack seen.
        end else begin
          word_idx_q <= word_idx_q + 1'b1;
          byte_idx_q <= FIRST_BYTE;
          gap_q      <= 1'b1;                                // Line idle between words.
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transmit port, shared with the load acknowledge
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (sending) begin
      o_tx_start = 1'b1;
      o_data_tx  = tx_byte;
    end else if (i_load_ack && !active_q) begin
      o_tx_start = 1'b1;
      o_data_tx  = CMD_LOAD;                                 // Ready for program.
    end else begin
      o_tx_start = 1'b0;
      o_data_tx  = '0;
    end
  end

  assign o_readout_select = word_idx_q;

endmodule

//--- hdl/rx_byte_decoder.sv
`timescale 1ns/1ps

module rx_byte_decoder (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_rx_done,
  input  debug_geom_pkg::byte_t i_data_rx,
  output logic                  o_byte_valid,
  output debug_geom_pkg::byte_t o_byte,
  output logic                  o_cmd_soft_reset,
  output logic                  o_cmd_load,
  output logic                  o_cmd_run,
  output logic                  o_run_step
);

  import debug_cmd_pkg::*;

  logic rx_done_q;
  logic rx_fall;
  logic is_soft_reset;
  logic is_load;
  logic is_run_cont;
  logic is_run_step;

  assign rx_fall = rx_done_q && !i_rx_done;                   // Byte complete.

  // Each command code is compared here and nowhere else.
  assign is_soft_reset = (i_data_rx == CMD_SOFT_RESET);
  assign is_load       = (i_data_rx == CMD_LOAD);
  assign is_run_cont   = (i_data_rx == CMD_RUN_CONT);
  assign is_run_step   = (i_data_rx == CMD_RUN_STEP);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rx_done_q        <= 1'b0;
      o_byte_valid     <= 1'b0;
      o_cmd_soft_reset <= 1'b0;
      o_cmd_load       <= 1'b0;
      o_cmd_run        <= 1'b0;
      o_run_step       <= 1'b0;
    end else begin
      rx_done_q        <= i_rx_done;
      o_byte_valid     <= rx_fall;                           // One-cycle strobe.
      o_cmd_soft_reset <= rx_fall && is_soft_reset;
      o_cmd_load       <= rx_fall && is_load;
      o_cmd_run        <= rx_fall && (is_run_cont || is_run_step);
      o_run_step       <= rx_fall && is_run_step;
    end
  end

  always_ff @(posedge i_clock) begin
    if (rx_fall) begin
      o_byte <= i_data_rx;                                    // Hold last byte.
    end
  end

endmodule

//--- verif/debug_unit_tb.sv
`timescale 1ns/1ps

module debug_unit_tb;

  import debug_geom_pkg::*;
  import debug_cmd_pkg::*;

  localparam int    CLK_PERIOD    = 100;
  localparam int    ADDR_WIDTH    = 11;
  localparam int    READOUT_WORDS = 10;
  localparam int    SEL_WIDTH     = $clog2(READOUT_WORDS);
  localparam int    PROG_MAX      = 20;
  localparam int    MAX_STEPS     = 3;
  localparam int    WAIT_LIMIT    = 200;                      // Cycles for one wait.
  localparam word_t HALT          = 32'hFFFF_FFFF;

  // Worst byte is 4 cycles high plus 5 idle.
  localparam int BYTE_CYCLES = 9;
  localparam int TOTAL_BYTES = 1 + 2 * (2 + (PROG_MAX + 1) * BYTES_PER_WORD) +
                               (MAX_STEPS + 1) * (1 + READOUT_WORDS * BYTES_PER_WORD * 2);
  localparam int WATCHDOG_NS = (TOTAL_BYTES * BYTE_CYCLES + 1000) * CLK_PERIOD;

  logic                 i_clock;
  logic                 i_reset;
  logic                 i_rx_done;
  byte_t                i_data_rx;
  logic                 i_soft_reset_ack;
  logic                 i_halt;
  word_t                i_readout_word;
  logic                 o_tx_start;
  byte_t                o_data_tx;
  logic                 o_soft_reset;
  logic                 o_enable_pc;
  logic                 o_enable_pipeline;
  logic                 o_mem_select_loader;
  logic                 o_write_mem;
  logic [ADDR_WIDTH-1:0] o_addr_mem;
  word_t                o_data_mem;
  logic [SEL_WIDTH-1:0] o_readout_select;

  int                   seed = 32'h1e84;
  word_t                readout_table [0:(1 << SEL_WIDTH)-1];  // Processor side data.
  word_t                program_words [0:PROG_MAX-1];
  int                   program_len = 0;
  int                   write_count = 0;
  int                   pc_count = 0;
  int                   pipe_count = 0;
  logic [SEL_WIDTH-1:0] last_select = '0;

  debug_unit #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .READOUT_WORDS (READOUT_WORDS)
  ) debug_unit_i (
    .i_clock             (i_clock),
    .i_reset             (i_reset),
    .i_rx_done           (i_rx_done),
    .i_data_rx           (i_data_rx),
    .o_tx_start          (o_tx_start),
    .o_data_tx           (o_data_tx),
    .o_soft_reset        (o_soft_reset),
    .o_enable_pc         (o_enable_pc),
    .o_enable_pipeline   (o_enable_pipeline),
    .o_mem_select_loader (o_mem_select_loader),
    .i_soft_reset_ack    (i_soft_reset_ack),
    .i_halt              (i_halt),
    .o_write_mem         (o_write_mem),
    .o_addr_mem          (o_addr_mem),
    .o_data_mem          (o_data_mem),
    .o_readout_select    (o_readout_select),
    .i_readout_word      (i_readout_word)
  );

  assign i_readout_word = readout_table[o_readout_select];    // Combinational read.

  initial begin
    i_clock = 1'b0;
    forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and waiting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERR at %0t ns: %s is 0x%0h, expected 0x%0h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic wait_cycle(inout int waited, input string what);
    @(negedge i_clock);
    waited++;
    if (waited > WAIT_LIMIT) begin
      abort_run($sformatf("Gave up waiting for %s, control FSM in %s", what,
                          debug_unit_i.debug_control_i.state_q.name()));
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Ack codes step by 8 from 0x08 for byte 3 up to 0x20 for byte 0.
  function automatic byte_t ack_code(input int b);
    return byte_t'(8 * (BYTES_PER_WORD - b));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Host and processor models
  ////////////////////////////////////////////////////////////////////////////

  // Called right after a falling edge.
  task automatic send_byte(input byte_t value);
    int high_cycles;
    int gap_cycles;
    high_cycles = rand_range(1, 4);
    gap_cycles  = rand_range(2, 5);                            // Lets the DUT act first.
    i_data_rx   = value;
    i_rx_done   = 1'b1;
    repeat (high_cycles) @(negedge i_clock);
    i_rx_done = 1'b0;
    repeat (gap_cycles) @(negedge i_clock);
  endtask

  task automatic send_word(input word_t value);
    for (int b = BYTES_PER_WORD - 1; b >= 0; b--) begin
      send_byte(value[b*BYTE_WIDTH +: BYTE_WIDTH]);            // MSB first.
    end
  endtask

  task automatic fill_table();
    for (int i = 0; i < (1 << SEL_WIDTH); i++) begin
      readout_table[i] = word_t'($random(seed));
    end
  endtask

  // Writes, enables and word gaps are watched every cycle.
  always @(negedge i_clock) begin
    if (i_reset === 1'b1) begin
      if (o_write_mem === 1'b1) begin
        if (write_count >= program_len) begin
          abort_run("Program memory was written outside a program load");
        end
        check_value("o_addr_mem", o_addr_mem, write_count);
        check_value("o_data_mem", o_data_mem, program_words[write_count]);
        write_count++;
      end
      if (o_readout_select !== last_select && o_readout_select != '0) begin
        check_value("o_tx_start", o_tx_start, 1'b0);          // Idle between words.
      end
      if (o_enable_pc === 1'b1) pc_count++;
      if (o_enable_pipeline === 1'b1) pipe_count++;
    end
    last_select = o_readout_select;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_idle();
    check_value("o_tx_start", o_tx_start, 1'b0);
    check_value("o_data_tx", o_data_tx, 8'h00);
    check_value("o_write_mem", o_write_mem, 1'b0);
    check_value("o_enable_pc", o_enable_pc, 1'b0);
    check_value("o_enable_pipeline", o_enable_pipeline, 1'b0);
    check_value("o_soft_reset", o_soft_reset, 1'b1);
    check_value("o_mem_select_loader", o_mem_select_loader, 1'b1);
  endtask

  task automatic do_soft_reset();
    int waited;
    int hold;
    waited = 0;
    send_byte(CMD_SOFT_RESET);
    while (o_soft_reset !== 1'b0) wait_cycle(waited, "soft reset");
    hold = rand_range(1, 8);
    repeat (hold) begin
      check_value("o_soft_reset", o_soft_reset, 1'b0);
      check_value("o_mem_select_loader", o_mem_select_loader, 1'b1);
      @(negedge i_clock);
    end
    i_soft_reset_ack = 1'b0;                                   // Processor reset done.
    i_halt           = 1'b0;
    @(negedge i_clock);
    check_value("o_soft_reset", o_soft_reset, 1'b1);
    check_value("o_tx_start", o_tx_start, 1'b1);
    check_value("o_data_tx", o_data_tx, 8'h01);
    check_value("o_mem_select_loader", o_mem_select_loader, 1'b1);
    i_soft_reset_ack = 1'b1;
  endtask

  task automatic load_program();
    int waited;
    waited      = 0;
    program_len = rand_range(3, PROG_MAX);
    for (int i = 0; i < program_len; i++) begin
      program_words[i] = word_t'($random(seed));
      if (program_words[i] == HALT) program_words[i][0] = 1'b0;
    end
    write_count = 0;
    send_byte(CMD_LOAD);
    check_value("o_tx_start", o_tx_start, 1'b0);
    for (int i = 0; i < program_len; i++) begin
      send_word(program_words[i]);
    end
    send_word(HALT);
    while (o_mem_select_loader !== 1'b0) wait_cycle(waited, "end of program load");
    check_value("write count", write_count, program_len);
  endtask

  task automatic do_readout();
    int    waited;
    byte_t wrong;
    for (int w = 0; w < READOUT_WORDS; w++) begin
      for (int b = BYTES_PER_WORD - 1; b >= 0; b--) begin
        waited = 0;
        while (o_tx_start !== 1'b1) wait_cycle(waited, "readout byte");
        check_value("o_readout_select", o_readout_select, w);
        check_value("o_data_tx", o_data_tx, readout_table[w][b*BYTE_WIDTH +: BYTE_WIDTH]);
        wrong = byte_t'($random(seed));
        if (wrong == ack_code(b)) wrong = wrong ^ 8'h40;
        send_byte(wrong);
        check_value("o_tx_start", o_tx_start, 1'b1);           // Still held.
        check_value("o_readout_select", o_readout_select, w);
        check_value("o_data_tx", o_data_tx, readout_table[w][b*BYTE_WIDTH +: BYTE_WIDTH]);
        send_byte(ack_code(b));
      end
    end
    @(negedge i_clock);
  endtask

  task automatic run_continuous();
    int waited;
    int run_cycles;
    waited = 0;
    fill_table();
    send_byte(CMD_RUN_CONT);
    while (o_enable_pc !== 1'b1) wait_cycle(waited, "continuous run");
    run_cycles = rand_range(2, 10);
    repeat (run_cycles) begin
      check_value("o_enable_pc", o_enable_pc, 1'b1);
      check_value("o_enable_pipeline", o_enable_pipeline, 1'b1);
      @(negedge i_clock);
    end
    i_halt = 1'b1;
    @(negedge i_clock);
    check_value("o_enable_pc", o_enable_pc, 1'b0);
    check_value("o_enable_pipeline", o_enable_pipeline, 1'b0);
    do_readout();
    check_idle();
  endtask

  task automatic run_step(input bit last);
    int waited;
    waited     = 0;
    pc_count   = 0;
    pipe_count = 0;
    fill_table();
    send_byte(CMD_RUN_STEP);
    while (o_tx_start !== 1'b1) wait_cycle(waited, "step readout");
    check_value("o_enable_pc cycles", pc_count, 1);
    check_value("o_enable_pipeline cycles", pipe_count, 1);
    if (last) i_halt = 1'b1;                                   // Program reached HALT.
    do_readout();
    if (last) begin
      check_idle();
    end else begin
      check_value("o_mem_select_loader", o_mem_select_loader, 1'b0);
      check_value("o_tx_start", o_tx_start, 1'b0);
    end
  endtask

  initial begin
    byte_t noise;
    int    steps;
    i_reset          = 1'b0;
    i_rx_done        = 1'b0;
    i_data_rx        = '0;
    i_soft_reset_ack = 1'b1;
    i_halt           = 1'b0;
    fill_table();
    repeat (8) @(negedge i_clock);
    i_reset = 1'b1;
    @(negedge i_clock);

    check_idle();
    check_value("o_readout_select", o_readout_select, 0);
    noise = byte_t'($random(seed));
    while (noise == 8'h00 || noise == 8'h01 || noise == 8'h03 || noise == 8'h07) begin
      noise = byte_t'($random(seed));
    end
    send_byte(noise);
    repeat (2) @(negedge i_clock);
    check_idle();

    do_soft_reset();
    load_program();
    run_continuous();

    do_soft_reset();                                           // Back in idle after run.
    load_program();
    steps = rand_range(2, MAX_STEPS);
    for (int s = 0; s < steps; s++) begin
      run_step(s == steps - 1);
    end

    $display("Finished with no errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the test sequence finished");
  end

endmodule
